// File: all.f
source/ddr_cmd_pkg.sv
source/scanline_pkg.sv
source/scanline_chn_mux.sv
source/linear_cmd_seq.sv
source/ddr_cmd_pins.sv
source/scanline_cmd_top.sv
test/tb_scanline_cmd.sv

// File: test/tb_scanline_cmd.sv
// random scanline requests, DDR pin command stream model, checks and timeout
module tb_scanline_cmd;
    import scanline_pkg::*;
    import ddr_cmd_pkg::*;

    localparam int NUM_CHN   = NUM_CHN_DEF;
    localparam int ADDR_BITS = ADDR_BITS_DEF;
    localparam int COL_BITS  = COL_BITS_DEF;
    localparam logic [NUM_CHN-1:0] RD_MASK = NUM_CHN'(4'b0101);    // even channels read
    localparam int T_RCD     = T_RCD_DEF;
    localparam int T_CCD     = T_CCD_DEF;
    localparam int T_PRE     = T_PRE_DEF;
    localparam int NUM_REQ   = 40;
    localparam int TIMEOUT   = NUM_REQ * (3 + T_RCD + 64 * T_CCD + T_PRE + 8);

    logic                                   clk;
    logic                                   rst_n;
    logic [NUM_CHN-1:0][BANK_BITS-1:0]      chn_bank;
    logic [NUM_CHN-1:0][ADDR_BITS-1:0]      chn_row;
    logic [NUM_CHN-1:0][COL_BITS-4:0]       chn_start_col;
    logic [NUM_CHN-1:0][NUM128_BITS-1:0]    chn_num128;
    logic [NUM_CHN-1:0]                     chn_start;
    logic                                   ddr_ras_n;
    logic                                   ddr_cas_n;
    logic                                   ddr_we_n;
    logic [BANK_BITS-1:0]                   ddr_ba;
    logic [ADDR_BITS-1:0]                   ddr_addr;
    logic                                   busy;
    logic                                   done;

    int          cyc = 0;                   // clock intervals since time 0
    logic [31:0] lfsr;
    int          q_cyc[$];                  // expected pin commands oldest first
    logic [2:0]  q_pins[$];                 // {ras_n, cas_n, we_n}
    logic [BANK_BITS-1:0] q_ba[$];
    logic [ADDR_BITS-1:0] q_addr[$];
    int          q_req[$];
    int          busy_lo;                   // sequencer busy window
    int          busy_hi;
    int          done_cyc;

    scanline_cmd_top #(
        .NUM_CHN (NUM_CHN), .ADDR_BITS (ADDR_BITS), .COL_BITS (COL_BITS),
        .CHN_RD_MASK (RD_MASK), .T_RCD (T_RCD), .T_CCD (T_CCD), .T_PRE (T_PRE)
    ) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hd0000001) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("mismatch %s: expected %0h, actual %0h", name, exp, act);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic push_cmd(input int c, input logic [2:0] pins, input logic [BANK_BITS-1:0] ba,
                            input logic [ADDR_BITS-1:0] addr, input int req);
        q_cyc.push_back(c);
        q_pins.push_back(pins);
        q_ba.push_back(ba);
        q_addr.push_back(addr);
        q_req.push_back(req);
    endtask

    // pin stream of one request started in interval t
    task automatic model_request(input int req, input int t, input int ch,
                                 input logic [BANK_BITS-1:0] ba, input logic [ADDR_BITS-1:0] row,
                                 input int sc, input int n128);
        int         n;
        int         pre_c;
        logic [2:0] col_pins;
        n        = (n128 == 0) ? 64 : n128;            // 0 means 64 words
        col_pins = RD_MASK[ch] ? 3'b101 : 3'b100;      // RD or WR
        push_cmd(t + 3, 3'b011, ba, row, req);          // ACT
        for (int i = 0; i < n; i++) begin
            push_cmd(t + 3 + T_RCD + i * T_CCD, col_pins, ba,
                     ADDR_BITS'(((sc + i) % (1 << (COL_BITS - 3))) * 8), req);
        end
        pre_c = t + 3 + T_RCD + (n - 1) * T_CCD + T_PRE;
        push_cmd(pre_c, 3'b010, ba, '0, req);           // PRE with A10 low
        busy_lo  = t + 2;
        busy_hi  = pre_c - 1;
        done_cyc = pre_c - 1;                           // done leads the pins by one
    endtask

    task automatic check_command();
        logic [2:0] pins;
        string      name;
        pins = {ddr_ras_n, ddr_cas_n, ddr_we_n};
        assert (q_cyc.size() > 0) else begin
            $display("unexpected command %b on the DDR pins at cycle %0d", pins, cyc);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
        name = $sformatf("req %0d", q_req[0]);
        assert (cyc == q_cyc[0]) else report_mismatch({name, " cycle"}, q_cyc[0], cyc);
        assert (pins == q_pins[0]) else report_mismatch({name, " ras/cas/we"}, q_pins[0], pins);
        assert (ddr_ba == q_ba[0]) else report_mismatch({name, " bank"}, q_ba[0], ddr_ba);
        if (q_pins[0] == 3'b010) begin
            assert (ddr_addr[10] == 1'b0)
                else report_mismatch({name, " pre a10"}, 0, ddr_addr[10]);
        end else begin
            assert (ddr_addr == q_addr[0])
                else report_mismatch({name, " addr"}, q_addr[0], ddr_addr);
        end
        void'(q_cyc.pop_front());
        void'(q_pins.pop_front());
        void'(q_ba.pop_front());
        void'(q_addr.pop_front());
        void'(q_req.pop_front());
    endtask

    // outputs sampled mid-cycle
    always @(negedge clk) begin
        logic exp_busy;
        exp_busy = (cyc >= busy_lo) && (cyc <= busy_hi);
        if (rst_n) begin
            assert (busy == exp_busy)
                else report_mismatch($sformatf("busy at %0d", cyc), exp_busy, busy);
            assert (done == (cyc == done_cyc))
                else report_mismatch($sformatf("done at %0d", cyc), (cyc == done_cyc), done);
            if ({ddr_ras_n, ddr_cas_n, ddr_we_n} != 3'b111) check_command();
        end
    end

    always @(posedge clk) begin
        if (cyc >= TIMEOUT) begin
            $display("timeout after %0d cycles, the DUT stopped finishing requests", cyc);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    end

    initial begin
        logic [NUM_CHN-1:0][BANK_BITS-1:0]   r_bank;
        logic [NUM_CHN-1:0][ADDR_BITS-1:0]   r_row;
        logic [NUM_CHN-1:0][COL_BITS-4:0]    r_col;
        logic [NUM_CHN-1:0][NUM128_BITS-1:0] r_num;
        logic [NUM_CHN-1:0]                  r_start;
        int                                  ch;
        lfsr          = 32'hba2874bf;
        rst_n         = 1'b0;
        chn_bank      = '0;
        chn_row       = '0;
        chn_start_col = '0;
        chn_num128    = '0;
        chn_start     = '0;
        busy_lo       = -1;                             // empty window before first start
        busy_hi       = -2;
        done_cyc      = -1;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        for (int k = 0; k < NUM_REQ; k++) begin
            for (int c = 0; c < NUM_CHN; c++) begin     // idle channels carry junk too
                r_bank[c] = rand_bits(BANK_BITS);
                r_row[c]  = rand_bits(ADDR_BITS);
                r_col[c]  = rand_bits(COL_BITS - 3);
                r_num[c]  = rand_bits(NUM128_BITS);
            end
            ch = rand_bits($clog2(NUM_CHN)) % NUM_CHN;
            if (k % 8 == 7) r_num[ch] = '0;              // full 64-word run
            if (k == 5) begin
                r_col[ch] = '1 - 1'b1;                  // column wraps after two bursts
                r_num[ch] = 6;
            end
            r_start     = '0;
            r_start[ch] = 1'b1;
            chn_bank      <= r_bank;
            chn_row       <= r_row;
            chn_start_col <= r_col;
            chn_num128    <= r_num;
            chn_start     <= r_start;
            model_request(k, cyc + 1, ch, r_bank[ch], r_row[ch], r_col[ch], r_num[ch]);
            @(posedge clk);
            chn_start <= '0;
            do @(posedge clk); while (!done);
            repeat (rand_bits(2)) @(posedge clk);       // idle 0..3
        end
        repeat (3) @(posedge clk);                      // last PRE onto the pins
        assert (q_cyc.size() == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("%0d expected commands never reached the DDR pins", q_cyc.size());
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
        $finish;
    end

endmodule

// File: source/scanline_cmd_top.sv
// scanline_cmd_top: channel mux, linear command sequencer and DDR pin encoder
module scanline_cmd_top #(
    parameter int NUM_CHN   = scanline_pkg::NUM_CHN_DEF,
    parameter int ADDR_BITS = scanline_pkg::ADDR_BITS_DEF,
    parameter int COL_BITS  = scanline_pkg::COL_BITS_DEF,
    parameter logic [NUM_CHN-1:0] CHN_RD_MASK = NUM_CHN'(4'b0101), // even channels read
    parameter int T_RCD     = ddr_cmd_pkg::T_RCD_DEF,
    parameter int T_CCD     = ddr_cmd_pkg::T_CCD_DEF,
    parameter int T_PRE     = ddr_cmd_pkg::T_PRE_DEF
) (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic [NUM_CHN-1:0][scanline_pkg::BANK_BITS-1:0]   chn_bank,
    input  logic [NUM_CHN-1:0][ADDR_BITS-1:0]                 chn_row,
    input  logic [NUM_CHN-1:0][COL_BITS-4:0]                  chn_start_col,
    input  logic [NUM_CHN-1:0][scanline_pkg::NUM128_BITS-1:0] chn_num128,
    input  logic [NUM_CHN-1:0]                                chn_start,
    output logic                                              ddr_ras_n,
    output logic                                              ddr_cas_n,
    output logic                                              ddr_we_n,
    output logic [scanline_pkg::BANK_BITS-1:0]                ddr_ba,
    output logic [ADDR_BITS-1:0]                              ddr_addr,
    output logic                                              busy,
    output logic                                              done
);
    import ddr_cmd_pkg::*;
    import scanline_pkg::*;

    // mux to sequencer
    logic [BANK_BITS-1:0]   req_bank;
    logic [ADDR_BITS-1:0]   req_row;
    logic [COL_BITS-4:0]    req_col;
    logic [NUM128_BITS-1:0] req_num128;
    logic                   req_rd;
    logic                   req_wr;

    // sequencer to pins
    ddr_cmd_t               seq_cmd;
    logic [BANK_BITS-1:0]   seq_bank;
    logic [ADDR_BITS-1:0]   seq_addr;

    scanline_chn_mux #(
        .NUM_CHN     (NUM_CHN),
        .ADDR_BITS   (ADDR_BITS),
        .COL_BITS    (COL_BITS),
        .CHN_RD_MASK (CHN_RD_MASK)
    ) i_chn_mux (
        .clk           (clk),
        .rst_n         (rst_n),
        .chn_bank      (chn_bank),
        .chn_row       (chn_row),
        .chn_start_col (chn_start_col),
        .chn_num128    (chn_num128),
        .chn_start     (chn_start),
        .bank          (req_bank),
        .row           (req_row),
        .start_col     (req_col),
        .num128        (req_num128),
        .start_rd      (req_rd),
        .start_wr      (req_wr)
    );

    linear_cmd_seq #(
        .ADDR_BITS (ADDR_BITS),
        .COL_BITS  (COL_BITS),
        .T_RCD     (T_RCD),
        .T_CCD     (T_CCD),
        .T_PRE     (T_PRE)
    ) i_cmd_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .bank      (req_bank),
        .row       (req_row),
        .start_col (req_col),
        .num128    (req_num128),
        .start_rd  (req_rd),
        .start_wr  (req_wr),
        .cmd       (seq_cmd),
        .cmd_bank  (seq_bank),
        .cmd_addr  (seq_addr),
        .busy      (busy),
        .done      (done)
    );

    ddr_cmd_pins #(
        .ADDR_BITS (ADDR_BITS)
    ) i_cmd_pins (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (seq_cmd),
        .cmd_bank  (seq_bank),
        .cmd_addr  (seq_addr),
        .ddr_ras_n (ddr_ras_n),
        .ddr_cas_n (ddr_cas_n),
        .ddr_we_n  (ddr_we_n),
        .ddr_ba    (ddr_ba),
        .ddr_addr  (ddr_addr)
    );

endmodule

// File: source/ddr_cmd_pins.sv
// ddr_cmd_pins: registers command kind, bank and address onto the DDR command pins
module ddr_cmd_pins #(
    parameter int ADDR_BITS = scanline_pkg::ADDR_BITS_DEF
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  ddr_cmd_pkg::ddr_cmd_t              cmd,
    input  logic [scanline_pkg::BANK_BITS-1:0] cmd_bank,
    input  logic [ADDR_BITS-1:0]               cmd_addr,
    output logic                               ddr_ras_n,
    output logic                               ddr_cas_n,
    output logic                               ddr_we_n,
    output logic [scanline_pkg::BANK_BITS-1:0] ddr_ba,
    output logic [ADDR_BITS-1:0]               ddr_addr
);
    import ddr_cmd_pkg::*;

    logic [2:0] pins_nxt;                  // {ras_n, cas_n, we_n}
    logic       is_cmd;                    // anything but NOP

    assign pins_nxt = pins_of(cmd);
    assign is_cmd   = (cmd != CMD_NOP);

    // strobes, NOP out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ddr_ras_n <= 1'b1;
            ddr_cas_n <= 1'b1;
            ddr_we_n  <= 1'b1;
        end else begin
            ddr_ras_n <= pins_nxt[2];
            ddr_cas_n <= pins_nxt[1];
            ddr_we_n  <= pins_nxt[0];
        end
    end

    // ba/addr only move with a real command, quiet pins otherwise
    always_ff @(posedge clk) begin
        if (is_cmd) begin
            ddr_ba   <= cmd_bank;
            ddr_addr <= cmd_addr;
        end
    end

    // sequencer only produces defined kinds
    a_cmd_legal: assert property (@(posedge clk) disable iff (!rst_n)
        cmd inside {CMD_NOP, CMD_ACT, CMD_RD, CMD_WR, CMD_PRE});

endmodule

// File: source/linear_cmd_seq.sv
// linear_cmd_seq: ACT / column burst / PRE sequencer with programmable gaps
module linear_cmd_seq #(
    parameter int ADDR_BITS = scanline_pkg::ADDR_BITS_DEF,
    parameter int COL_BITS  = scanline_pkg::COL_BITS_DEF,
    parameter int T_RCD     = ddr_cmd_pkg::T_RCD_DEF,
    parameter int T_CCD     = ddr_cmd_pkg::T_CCD_DEF,
    parameter int T_PRE     = ddr_cmd_pkg::T_PRE_DEF
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic [scanline_pkg::BANK_BITS-1:0]   bank,
    input  logic [ADDR_BITS-1:0]                 row,
    input  logic [COL_BITS-4:0]                  start_col,  // in 8-bursts
    input  logic [scanline_pkg::NUM128_BITS-1:0] num128,     // 0 means 64
    input  logic                                 start_rd,
    input  logic                                 start_wr,
    output ddr_cmd_pkg::ddr_cmd_t                cmd,
    output logic [scanline_pkg::BANK_BITS-1:0]   cmd_bank,
    output logic [ADDR_BITS-1:0]                 cmd_addr,
    output logic                                 busy,       // ACT issued until PRE issued
    output logic                                 done        // with PRE
);
    import ddr_cmd_pkg::*;
    import scanline_pkg::*;

    localparam int REM_BITS = NUM128_BITS + 1;              // holds 64
    localparam int GAP_MAX  = (T_RCD > T_CCD) ? ((T_RCD > T_PRE) ? T_RCD : T_PRE)
                                              : ((T_CCD > T_PRE) ? T_CCD : T_PRE);
    localparam int GAP_BITS = $clog2(GAP_MAX + 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ACT,                                              // ACT on cmd
        S_WAIT,                                             // column commands and gaps
        S_PRE                                               // last gap, then PRE
    } state_t;

    state_t                 state;
    logic [GAP_BITS-1:0]    gap_cnt;       // clocks left to next command
    logic [REM_BITS-1:0]    rem_cnt;       // bursts still to issue
    logic [COL_BITS-4:0]    col_cnt;       // current column in 8-bursts
    logic                   dir_rd;        // 1: RD, 0: WR
    logic [BANK_BITS-1:0]   bank_r;
    logic [ADDR_BITS-1:0]   row_r;
    logic [ADDR_BITS-1:0]   col_addr;
    logic                   start;
    logic                   gap_end;

    assign start    = start_rd | start_wr;
    assign gap_end  = (gap_cnt == '0);
    // col*8, wraps in COL_BITS, A10 stays low (no auto-precharge)
    assign col_addr = ADDR_BITS'({col_cnt, 3'b000});

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= S_IDLE;
            gap_cnt <= '0;
            rem_cnt <= '0;
            col_cnt <= '0;
            dir_rd  <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state   <= S_ACT;
                        rem_cnt <= (num128 == '0) ? (REM_BITS'(1) << NUM128_BITS)
                                                  : REM_BITS'(num128);
                        col_cnt <= start_col;
                        dir_rd  <= start_rd;
                    end
                end
                S_ACT: begin
                    state   <= S_WAIT;
                    gap_cnt <= GAP_BITS'(T_RCD - 1);        // tRCD to first column
                end
                S_WAIT: begin
                    if (gap_end) begin                      // column issued now
                        col_cnt <= col_cnt + 1'b1;
                        rem_cnt <= rem_cnt - 1'b1;
                        if (rem_cnt == REM_BITS'(1)) begin
                            state   <= S_PRE;
                            gap_cnt <= GAP_BITS'(T_PRE - 1);
                        end else begin
                            gap_cnt <= GAP_BITS'(T_CCD - 1);
                        end
                    end else begin
                        gap_cnt <= gap_cnt - 1'b1;
                    end
                end
                S_PRE: begin
                    if (gap_end) begin
                        state <= S_IDLE;                    // PRE issued now
                    end else begin
                        gap_cnt <= gap_cnt - 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // bank and row of current request
    always_ff @(posedge clk) begin
        if (start && (state == S_IDLE)) begin
            bank_r <= bank;
            row_r  <= row;
        end
    end

    always_comb begin
        cmd      = CMD_NOP;
        cmd_addr = '0;                                      // PRE: A10 low, one bank
        case (state)
            S_ACT: begin
                cmd      = CMD_ACT;
                cmd_addr = row_r;
            end
            S_WAIT: begin
                if (gap_end) begin
                    cmd      = dir_rd ? CMD_RD : CMD_WR;
                    cmd_addr = col_addr;
                end
            end
            S_PRE:   cmd = gap_end ? CMD_PRE : CMD_NOP;
            default: cmd = CMD_NOP;
        endcase
    end

    assign cmd_bank = bank_r;
    assign busy     = (state != S_IDLE);
    assign done     = (state == S_PRE) && gap_end;

    // direction tag from the mux is exclusive
    a_start_dir: assert property (@(posedge clk) disable iff (!rst_n)
        !(start_rd && start_wr));
    // no queuing, caller waits for done
    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> !busy);

endmodule

// File: source/scanline_chn_mux.sv
// scanline_chn_mux: picks the starting channel's request, tags read/write, registers it
module scanline_chn_mux #(
    parameter int NUM_CHN   = scanline_pkg::NUM_CHN_DEF,
    parameter int ADDR_BITS = scanline_pkg::ADDR_BITS_DEF,
    parameter int COL_BITS  = scanline_pkg::COL_BITS_DEF,
    parameter logic [NUM_CHN-1:0] CHN_RD_MASK = '0            // 1 = read channel
) (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic [NUM_CHN-1:0][scanline_pkg::BANK_BITS-1:0]   chn_bank,      // per channel bank
    input  logic [NUM_CHN-1:0][ADDR_BITS-1:0]                 chn_row,       // per channel row
    input  logic [NUM_CHN-1:0][COL_BITS-4:0]                  chn_start_col, // in 8-bursts
    input  logic [NUM_CHN-1:0][scanline_pkg::NUM128_BITS-1:0] chn_num128,    // 0 means 64
    input  logic [NUM_CHN-1:0]                                chn_start,     // one-cycle pulses
    output logic [scanline_pkg::BANK_BITS-1:0]                bank,
    output logic [ADDR_BITS-1:0]                              row,
    output logic [COL_BITS-4:0]                               start_col,
    output logic [scanline_pkg::NUM128_BITS-1:0]              num128,
    output logic                                              start_rd,      // read sequence
    output logic                                              start_wr       // write sequence
);
    import scanline_pkg::*;

    logic [BANK_BITS-1:0]   sel_bank;      // or-ed fields of pulsing channel
    logic [ADDR_BITS-1:0]   sel_row;
    logic [COL_BITS-4:0]    sel_col;
    logic [NUM128_BITS-1:0] sel_num128;
    logic                   sel_rd;        // direction of pulsing channel
    logic                   any_start;

    assign any_start = |chn_start;

    // and-or select, idle channels contribute zeros
    always_comb begin
        sel_bank   = '0;
        sel_row    = '0;
        sel_col    = '0;
        sel_num128 = '0;
        sel_rd     = 1'b0;
        for (int i = 0; i < NUM_CHN; i++) begin
            if (chn_start[i]) begin
                sel_bank   |= chn_bank[i];
                sel_row    |= chn_row[i];
                sel_col    |= chn_start_col[i];
                sel_num128 |= chn_num128[i];
                sel_rd     |= CHN_RD_MASK[i];
            end
        end
    end

    // request fields, held until next start
    always_ff @(posedge clk) begin
        if (any_start) begin
            bank      <= sel_bank;
            row       <= sel_row;
            start_col <= sel_col;
            num128    <= sel_num128;
        end
    end

    // start pulses, one cycle behind chn_start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_rd <= 1'b0;
            start_wr <= 1'b0;
        end else begin
            start_rd <= any_start & sel_rd;
            start_wr <= any_start & ~sel_rd;
        end
    end

    // callers never start two channels together
    a_start_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(chn_start));

endmodule

// File: source/scanline_pkg.sv
// scanline_pkg: scanline request field widths, channel count and address width defaults
package scanline_pkg;

    // request fields
    localparam int BANK_BITS   = 3;        // DDR3 has 8 banks
    localparam int NUM128_BITS = 6;        // 128-bit words per request, 0 = 64

    // defaults for the top level
    localparam int NUM_CHN_DEF   = 4;      // scanline channels
    localparam int ADDR_BITS_DEF = 15;     // row address width
    localparam int COL_BITS_DEF  = 10;     // column address width

endpackage

// File: source/ddr_cmd_pkg.sv
// ddr_cmd_pkg: DDR command kinds, ras/cas/we pin encodings, default command gaps
package ddr_cmd_pkg;

    // command kind passed from sequencer to pin encoder
    typedef enum logic [2:0] {
        CMD_NOP = 3'd0,                    // no command, all strobes high
        CMD_ACT = 3'd1,                    // open row
        CMD_RD  = 3'd2,                    // column read, BL8
        CMD_WR  = 3'd3,                    // column write, BL8
        CMD_PRE = 3'd4                     // close row, single bank
    } ddr_cmd_t;

    // default gaps in clocks
    localparam int T_RCD_DEF = 4;          // ACT to first column command
    localparam int T_CCD_DEF = 4;          // column to column, one BL8
    localparam int T_PRE_DEF = 6;          // last column to PRE

    // {ras_n, cas_n, we_n} for a command kind
    function automatic logic [2:0] pins_of(ddr_cmd_t kind);
        logic [2:0] pins;
        case (kind)
            CMD_ACT: pins = 3'b011;        // ras low
            CMD_RD:  pins = 3'b101;        // cas low
            CMD_WR:  pins = 3'b100;        // cas, we low
            CMD_PRE: pins = 3'b010;        // ras, we low
            default: pins = 3'b111;        // nop
        endcase
        return pins;
    endfunction

endpackage
